// File: rtl/lc4_pkg.sv
/* LC4 subset types, opcodes and stage payloads.
   Only ADD/SUB/AND, CONST, LDR, STR and BR are decoded. Every other opcode is a NOP */
`default_nettype none

package lc4_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;
   // Negative, zero, positive from the top bit down
   typedef logic [2:0]  nzp_t;
   typedef logic [1:0]  stall_t;

   localparam stall_t STALL_NONE  = 2'd0;
   localparam stall_t STALL_FLUSH = 2'd2;
   localparam stall_t STALL_LOAD  = 2'd3;

   localparam word_t RESET_PC_DEFAULT = 16'h8200;

   // Instruction bits 15:12
   localparam logic [3:0] OP_BR    = 4'b0000;
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;

   // Operand bypass sources
   localparam logic [1:0] FWD_REG = 2'd0;
   localparam logic [1:0] FWD_M   = 2'd1;
   localparam logic [1:0] FWD_W   = 2'd2;

   typedef struct packed {
      reg_sel_t r1sel;
      reg_sel_t r2sel;
      reg_sel_t wsel;
      logic     r1re;
      logic     r2re;
      logic     regfile_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
   } ctrl_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      stall_t stall;
   } fd_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  rs;
      word_t  rt;
      stall_t stall;
   } dx_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  alu;
      word_t  rt;
      stall_t stall;
   } xm_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  result;
      word_t  dmem_addr;
      word_t  dmem_data;
      nzp_t   nzp;
      stall_t stall;
   } mw_t;

   // Bubbles carry no enables and trace as a flush
   localparam fd_t FD_BUBBLE = '{pc: '0, insn: '0, stall: STALL_FLUSH};
   localparam dx_t DX_BUBBLE = '{pc: '0, insn: '0, ctrl: '0, rs: '0, rt: '0,
                                 stall: STALL_FLUSH};
   localparam xm_t XM_BUBBLE = '{pc: '0, insn: '0, ctrl: '0, alu: '0, rt: '0,
                                 stall: STALL_FLUSH};
   localparam mw_t MW_BUBBLE = '{pc: '0, insn: '0, ctrl: '0, result: '0, dmem_addr: '0,
                                 dmem_data: '0, nzp: '0, stall: STALL_FLUSH};

endpackage

`default_nettype wire

// File: rtl/pipe_latch.sv
/* Pipeline stage register for any packed payload.
   Bubble and reset both load BUBBLE. Hold and bubble must not be raised together */
`timescale 1ns/10ps
`default_nettype none

module pipe_latch #(
   parameter type      payload_t = logic [15:0],
   parameter payload_t BUBBLE    = '0
) (
   input  logic     gwe,
   input  logic     i_reset,
   input  logic     i_hold,
   input  logic     i_bubble,
   input  payload_t i_payload,
   output payload_t o_payload
);

   always_ff @(posedge gwe) begin
      if (i_reset || i_bubble) begin
         o_payload <= BUBBLE;
      end else if (!i_hold) begin
         o_payload <= i_payload;
      end
   end

   // Stall and flush come from different X-stage instruction classes
   a_hold_bubble_excl: assert property (
      @(posedge gwe) disable iff (i_reset) !(i_hold && i_bubble))
      else $error("stage latch held and bubbled in the same cycle");

endmodule

`default_nettype wire

// File: rtl/lc4_decoder.sv
/* Control decode for the kept LC4 subset.
   MUL, DIV, OR, NOT, XOR and every dropped opcode come out as a NOP */
`timescale 1ns/10ps
`default_nettype none

module lc4_decoder import lc4_pkg::*; (
   input  word_t i_insn,
   output ctrl_t o_ctrl
);

   logic [3:0] opcode;
   logic       imm_form;
   logic       arith_ok;
   logic       logic_ok;

   assign opcode   = i_insn[15:12];
   assign imm_form = i_insn[5];

   // ADD, SUB and ADD-immediate
   assign arith_ok = imm_form || (i_insn[5:3] == 3'b000) || (i_insn[5:3] == 3'b010);
   // AND and AND-immediate
   assign logic_ok = imm_form || (i_insn[5:3] == 3'b000);

   always_comb begin
      o_ctrl       = '0;
      o_ctrl.r1sel = i_insn[8:6];
      o_ctrl.r2sel = i_insn[2:0];
      o_ctrl.wsel  = i_insn[11:9];
      case (opcode)
         OP_ARITH, OP_LOGIC: begin
            if ((opcode == OP_ARITH) ? arith_ok : logic_ok) begin
               o_ctrl.r1re       = 1'b1;
               o_ctrl.r2re       = !imm_form;
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.nzp_we     = 1'b1;
            end
         end
         OP_LDR: begin
            o_ctrl.r1re       = 1'b1;
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we     = 1'b1;
            o_ctrl.is_load    = 1'b1;
         end
         OP_STR: begin
            // Base on r1, data register on r2
            o_ctrl.r1re     = 1'b1;
            o_ctrl.r2re     = 1'b1;
            o_ctrl.r2sel    = i_insn[11:9];
            o_ctrl.is_store = 1'b1;
         end
         OP_CONST: begin
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.nzp_we     = 1'b1;
         end
         OP_BR: begin
            o_ctrl.is_branch = 1'b1;
         end
         default: begin
            o_ctrl.is_branch = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/lc4_regfile.sv
/* Eight 16-bit registers, two combinational reads, one write at the clock edge.
   A read of the register being written returns the new value */
`timescale 1ns/10ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_reset,
   input  reg_sel_t i_rs,
   input  reg_sel_t i_rt,
   input  reg_sel_t i_rd,
   input  word_t    i_wdata,
   input  logic     i_rd_we,
   output word_t    o_rs_data,
   output word_t    o_rt_data
);

   word_t regs [0:7];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Write-through gives the W to D bypass
   assign o_rs_data = (i_rd_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

   // Write select comes down the whole pipe from the decoder
   a_rd_known: assert property (
      @(posedge gwe) disable iff (i_reset) i_rd_we |-> !$isunknown(i_rd))
      else $error("register write with unknown destination");

endmodule

`default_nettype wire

// File: rtl/lc4_alu.sv
/* Execute-stage result for the kept LC4 subset, with a plain adder.
   Undecoded opcodes give zero */
`timescale 1ns/10ps
`default_nettype none

module lc4_alu import lc4_pkg::*; (
   input  word_t i_insn,
   input  word_t i_pc,
   input  word_t i_r1data,
   input  word_t i_r2data,
   output word_t o_result
);

   word_t imm5;
   word_t imm6;
   word_t imm9;

   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      case (i_insn[15:12])
         OP_ARITH: begin
            if (i_insn[5]) begin
               o_result = i_r1data + imm5;
            end else if (i_insn[4]) begin
               o_result = i_r1data - i_r2data;
            end else begin
               o_result = i_r1data + i_r2data;
            end
         end
         OP_LOGIC: begin
            o_result = i_r1data & (i_insn[5] ? imm5 : i_r2data);
         end
         // Effective address
         OP_LDR, OP_STR: o_result = i_r1data + imm6;
         OP_CONST:       o_result = imm9;
         // Branch target
         OP_BR:          o_result = i_pc + 16'd1 + imm9;
         default:        o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
/* Bypass selects, load-use stall and branch flush for the five-stage pipe.
   Loads in M are not bypassed to X; the load-use stall or W to M covers them */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import lc4_pkg::*; (
   input  logic       gwe,
   input  logic       i_reset,
   input  ctrl_t      i_d_ctrl,
   input  ctrl_t      i_x_ctrl,
   input  ctrl_t      i_m_ctrl,
   input  ctrl_t      i_w_ctrl,
   input  logic       i_branch_taken,
   output logic       o_stall_load,
   output logic       o_flush,
   output logic [1:0] o_fwd_rs,
   output logic [1:0] o_fwd_rt,
   output logic       o_fwd_store,
   output logic       o_nzp_from_m
);

   logic m_fwd_ok;
   logic w_fwd_ok;

   // Pick the youngest ready writer of a register
   function automatic logic [1:0] fwd_pick(input reg_sel_t sel, input ctrl_t m_ctrl,
                                           input ctrl_t w_ctrl, input logic m_ok,
                                           input logic w_ok);
      if (m_ok && (m_ctrl.wsel == sel)) begin
         return FWD_M;
      end else if (w_ok && (w_ctrl.wsel == sel)) begin
         return FWD_W;
      end
      return FWD_REG;
   endfunction

   assign m_fwd_ok = i_m_ctrl.regfile_we && !i_m_ctrl.is_load;
   assign w_fwd_ok = i_w_ctrl.regfile_we;

   assign o_fwd_rs = fwd_pick(i_x_ctrl.r1sel, i_m_ctrl, i_w_ctrl, m_fwd_ok, w_fwd_ok);
   assign o_fwd_rt = fwd_pick(i_x_ctrl.r2sel, i_m_ctrl, i_w_ctrl, m_fwd_ok, w_fwd_ok);

   // Store data of a just-loaded register
   assign o_fwd_store = w_fwd_ok && i_m_ctrl.is_store && (i_w_ctrl.wsel == i_m_ctrl.r2sel);

   assign o_stall_load = i_x_ctrl.is_load &&
      ((i_d_ctrl.r1re && (i_d_ctrl.r1sel == i_x_ctrl.wsel)) ||
       (i_d_ctrl.r2re && !i_d_ctrl.is_store && (i_d_ctrl.r2sel == i_x_ctrl.wsel)));

   assign o_flush      = i_branch_taken;
   assign o_nzp_from_m = i_m_ctrl.nzp_we;

   // X holds a load or a branch, never both, so flush never meets a stall
   a_flush_stall_excl: assert property (
      @(posedge gwe) disable iff (i_reset) !(o_flush && o_stall_load))
      else $error("branch flush and load-use stall in the same cycle");

endmodule

`default_nettype wire

// File: rtl/lc4_pipeline.sv
/* Five-stage LC4 subset pipeline. Both memories read combinationally.
   Branches resolve in X and flush two slots; the trace port reports W every cycle */
`timescale 1ns/10ps
`default_nettype none

module lc4_pipeline import lc4_pkg::*; #(
   parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
   input  logic     gwe,
   input  logic     i_reset,
   output word_t    o_cur_pc,
   input  word_t    i_cur_insn,
   output word_t    o_dmem_addr,
   input  word_t    i_cur_dmem_data,
   output logic     o_dmem_we,
   output word_t    o_dmem_towrite,
   output stall_t   o_test_stall,
   output word_t    o_test_cur_pc,
   output word_t    o_test_cur_insn,
   output logic     o_test_regfile_we,
   output reg_sel_t o_test_regfile_wsel,
   output word_t    o_test_regfile_data,
   output logic     o_test_nzp_we,
   output nzp_t     o_test_nzp_new_bits,
   output logic     o_test_dmem_we,
   output word_t    o_test_dmem_addr,
   output word_t    o_test_dmem_data
);

   word_t      pc;
   nzp_t       nzp_reg;
   fd_t        fd_next, fd_q;
   dx_t        dx_next, dx_q;
   xm_t        xm_next, xm_q;
   mw_t        mw_next, mw_q;
   ctrl_t      d_ctrl;
   word_t      d_rs_data, d_rt_data;
   word_t      x_rs, x_rt, x_alu;
   nzp_t       branch_nzp;
   logic       branch_taken;
   word_t      m_store_data, m_result, m_load_data;
   nzp_t       m_nzp;
   logic       stall_load, flush, fwd_store, nzp_from_m;
   logic [1:0] fwd_rs, fwd_rt;

   function automatic word_t bypass(input logic [1:0] sel, input word_t reg_val,
                                    input word_t m_val, input word_t w_val);
      case (sel)
         FWD_M:   return m_val;
         FWD_W:   return w_val;
         default: return reg_val;
      endcase
   endfunction

   // Fetch
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc <= RESET_PC;
      end else if (flush) begin
         pc <= x_alu;
      end else if (!stall_load) begin
         pc <= pc + 16'd1;
      end
   end

   assign o_cur_pc = pc;
   assign fd_next  = '{pc: pc, insn: i_cur_insn, stall: STALL_NONE};

   pipe_latch #(.payload_t(fd_t), .BUBBLE(FD_BUBBLE)) u_fd_latch (
      .gwe(gwe), .i_reset(i_reset), .i_hold(stall_load), .i_bubble(flush),
      .i_payload(fd_next), .o_payload(fd_q));

   // Decode
   lc4_decoder u_decoder (.i_insn(fd_q.insn), .o_ctrl(d_ctrl));

   lc4_regfile u_regfile (
      .gwe(gwe), .i_reset(i_reset), .i_rs(d_ctrl.r1sel), .i_rt(d_ctrl.r2sel),
      .i_rd(mw_q.ctrl.wsel), .i_wdata(mw_q.result), .i_rd_we(mw_q.ctrl.regfile_we),
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data));

   always_comb begin
      dx_next = '{pc: fd_q.pc, insn: fd_q.insn, ctrl: d_ctrl, rs: d_rs_data,
                  rt: d_rt_data, stall: fd_q.stall};
      // Load-use bubble goes into X while D waits a cycle
      if (stall_load) begin
         dx_next       = DX_BUBBLE;
         dx_next.stall = STALL_LOAD;
      end
   end

   pipe_latch #(.payload_t(dx_t), .BUBBLE(DX_BUBBLE)) u_dx_latch (
      .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(flush),
      .i_payload(dx_next), .o_payload(dx_q));

   // Execute
   assign x_rs = bypass(fwd_rs, dx_q.rs, xm_q.alu, mw_q.result);
   assign x_rt = bypass(fwd_rt, dx_q.rt, xm_q.alu, mw_q.result);

   lc4_alu u_alu (
      .i_insn(dx_q.insn), .i_pc(dx_q.pc), .i_r1data(x_rs), .i_r2data(x_rt),
      .o_result(x_alu));

   // Condition codes of the nearest older writer
   assign branch_nzp   = nzp_from_m ? m_nzp : nzp_reg;
   assign branch_taken = dx_q.ctrl.is_branch && |(branch_nzp & dx_q.insn[11:9]);

   assign xm_next = '{pc: dx_q.pc, insn: dx_q.insn, ctrl: dx_q.ctrl, alu: x_alu,
                      rt: x_rt, stall: dx_q.stall};

   pipe_latch #(.payload_t(xm_t), .BUBBLE(XM_BUBBLE)) u_xm_latch (
      .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(1'b0),
      .i_payload(xm_next), .o_payload(xm_q));

   hazard_unit u_hazard (
      .gwe(gwe), .i_reset(i_reset), .i_d_ctrl(d_ctrl), .i_x_ctrl(dx_q.ctrl),
      .i_m_ctrl(xm_q.ctrl), .i_w_ctrl(mw_q.ctrl), .i_branch_taken(branch_taken),
      .o_stall_load(stall_load), .o_flush(flush), .o_fwd_rs(fwd_rs), .o_fwd_rt(fwd_rt),
      .o_fwd_store(fwd_store), .o_nzp_from_m(nzp_from_m));

   // Memory
   assign m_store_data = fwd_store ? mw_q.result : xm_q.rt;
   assign m_load_data  = xm_q.ctrl.is_load ? i_cur_dmem_data : '0;
   assign m_result     = xm_q.ctrl.is_load ? i_cur_dmem_data : xm_q.alu;
   assign m_nzp        = {m_result[15], m_result == '0, !m_result[15] && (m_result != '0)};

   assign o_dmem_we      = xm_q.ctrl.is_store;
   assign o_dmem_addr    = (xm_q.ctrl.is_load || xm_q.ctrl.is_store) ? xm_q.alu : '0;
   assign o_dmem_towrite = xm_q.ctrl.is_store ? m_store_data : '0;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_reg <= '0;
      end else if (xm_q.ctrl.nzp_we) begin
         nzp_reg <= m_nzp;
      end
   end

   assign mw_next = '{pc: xm_q.pc, insn: xm_q.insn, ctrl: xm_q.ctrl, result: m_result,
                      dmem_addr: o_dmem_addr,
                      dmem_data: xm_q.ctrl.is_store ? m_store_data : m_load_data,
                      nzp: xm_q.ctrl.nzp_we ? m_nzp : '0, stall: xm_q.stall};

   pipe_latch #(.payload_t(mw_t), .BUBBLE(MW_BUBBLE)) u_mw_latch (
      .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(1'b0),
      .i_payload(mw_next), .o_payload(mw_q));

   // Writeback trace
   assign o_test_stall        = mw_q.stall;
   assign o_test_cur_pc       = mw_q.pc;
   assign o_test_cur_insn     = mw_q.insn;
   assign o_test_regfile_we   = mw_q.ctrl.regfile_we;
   assign o_test_regfile_wsel = mw_q.ctrl.wsel;
   assign o_test_regfile_data = mw_q.ctrl.regfile_we ? mw_q.result : '0;
   assign o_test_nzp_we       = mw_q.ctrl.nzp_we;
   assign o_test_nzp_new_bits = mw_q.nzp;
   assign o_test_dmem_we      = mw_q.ctrl.is_store;
   assign o_test_dmem_addr    = mw_q.dmem_addr;
   assign o_test_dmem_data    = mw_q.dmem_data;

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
/* Testbench clock and reset source. Period 10 ns.
   Reset is high for the first 4 rising edges */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
   output logic o_gwe,
   output logic o_reset
);

   initial begin
      o_gwe = 1'b0;
      forever #5 o_gwe = ~o_gwe;
   end

   // Released on the rising edge like every other driven input
   initial begin
      o_reset = 1'b1;
      repeat (4) @(posedge o_gwe);
      o_reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: verif/lc4_tb.sv
/* Testbench for the LC4 subset pipeline. Program ROM at 16'h8200, 256-word data RAM.
   Expected trace is built by an in-order ISA model before the run; outputs sampled on negedge */
`timescale 1ns/10ps
`default_nettype none

module lc4_tb import lc4_pkg::*; ();

   localparam int PROG_LEN = 30;
   localparam int MAX_EXP  = 64;

   logic     gwe, reset;
   word_t    cur_pc, cur_insn, dmem_addr, dmem_rdata, dmem_towrite;
   logic     dmem_we;
   stall_t   test_stall;
   word_t    test_pc, test_insn, test_rf_data, test_dmem_addr, test_dmem_data;
   logic     test_rf_we, test_nzp_we, test_dmem_we;
   reg_sel_t test_wsel;
   nzp_t     test_nzp;

   word_t    prog [0:31];
   word_t    ram [0:255];
   word_t    exp_pc [0:MAX_EXP-1], exp_insn [0:MAX_EXP-1], exp_rf_data [0:MAX_EXP-1];
   word_t    exp_addr [0:MAX_EXP-1], exp_data [0:MAX_EXP-1];
   logic     exp_rf_we [0:MAX_EXP-1], exp_nzp_we [0:MAX_EXP-1], exp_dmem_we [0:MAX_EXP-1];
   reg_sel_t exp_wsel [0:MAX_EXP-1];
   nzp_t     exp_nzp [0:MAX_EXP-1];
   int       exp_bub [0:MAX_EXP-1];
   stall_t   exp_kind [0:MAX_EXP-1];
   int       n_exp;
   int       timeout_limit = 1000;
   int       cycles = 0;

   tb_clock u_clock (.o_gwe(gwe), .o_reset(reset));

   lc4_pipeline #(.RESET_PC(RESET_PC_DEFAULT)) UUT (
      .gwe(gwe), .i_reset(reset), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
      .o_dmem_addr(dmem_addr), .i_cur_dmem_data(dmem_rdata), .o_dmem_we(dmem_we),
      .o_dmem_towrite(dmem_towrite), .o_test_stall(test_stall), .o_test_cur_pc(test_pc),
      .o_test_cur_insn(test_insn), .o_test_regfile_we(test_rf_we),
      .o_test_regfile_wsel(test_wsel), .o_test_regfile_data(test_rf_data),
      .o_test_nzp_we(test_nzp_we), .o_test_nzp_new_bits(test_nzp),
      .o_test_dmem_we(test_dmem_we), .o_test_dmem_addr(test_dmem_addr),
      .o_test_dmem_data(test_dmem_data));

   function automatic word_t ram_fill(input logic [7:0] a);
      return {a ^ 8'hC3, ~a};
   endfunction

   function automatic word_t rom_read(input word_t pc);
      word_t off;
      off = pc - RESET_PC_DEFAULT;
      if (off < 16'(PROG_LEN)) begin
         return prog[off[4:0]];
      end
      return '0;
   endfunction

   function automatic nzp_t nzp_of(input word_t v);
      if (v[15]) begin
         return 3'b100;
      end else if (v == '0) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

   // Both memories read combinationally
   assign cur_insn   = rom_read(cur_pc);
   assign dmem_rdata = ram[dmem_addr[7:0]];

   always @(posedge gwe) begin
      if (reset) begin
         for (int i = 0; i < 256; i++) begin
            ram[i] <= ram_fill(8'(i));
         end
      end else if (dmem_we) begin
         ram[dmem_addr[7:0]] <= dmem_towrite;
      end
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "run stopped");
   endtask

   always @(posedge gwe) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_limit) begin
         stop_run("timeout: the expected retirements did not all appear in time");
      end
   end

   // Instruction encoders
   function automatic word_t enc_const(input reg_sel_t d, input logic [8:0] imm);
      return {OP_CONST, d, imm};
   endfunction

   function automatic word_t enc_rrr(input logic [3:0] op, input reg_sel_t d,
                                     input reg_sel_t s, input logic [2:0] sub,
                                     input reg_sel_t t);
      return {op, d, s, sub, t};
   endfunction

   function automatic word_t enc_ri(input logic [3:0] op, input reg_sel_t d,
                                    input reg_sel_t s, input logic [4:0] imm);
      return {op, d, s, 1'b1, imm};
   endfunction

   function automatic word_t enc_mem(input logic [3:0] op, input reg_sel_t r,
                                     input reg_sel_t base, input logic [5:0] off);
      return {op, r, base, off};
   endfunction

   function automatic word_t enc_br(input nzp_t cond, input logic [8:0] off);
      return {OP_BR, cond, off};
   endfunction

   task automatic build_program();
      logic [8:0] rnd_a, rnd_b, rnd_c;
      rnd_a = 9'($urandom(22));
      rnd_b = 9'($urandom_range(511, 0));
      rnd_c = 9'($urandom_range(511, 0));
      // Dependent arithmetic chain
      prog[0]  = enc_const(3'd1, rnd_a);
      prog[1]  = enc_const(3'd2, rnd_b);
      prog[2]  = enc_rrr(OP_ARITH, 3'd3, 3'd1, 3'b000, 3'd2);
      prog[3]  = enc_rrr(OP_ARITH, 3'd4, 3'd3, 3'b010, 3'd1);
      prog[4]  = enc_rrr(OP_LOGIC, 3'd5, 3'd4, 3'b000, 3'd3);
      prog[5]  = enc_ri(OP_ARITH, 3'd5, 3'd5, 5'b11101);
      prog[6]  = enc_ri(OP_LOGIC, 3'd7, 3'd5, 5'b01111);
      // Stores, loads, load-use and load then store
      prog[7]  = enc_const(3'd6, 9'd16);
      prog[8]  = enc_mem(OP_STR, 3'd3, 3'd6, 6'd2);
      prog[9]  = enc_mem(OP_STR, 3'd5, 3'd6, 6'd3);
      prog[10] = enc_mem(OP_LDR, 3'd1, 3'd6, 6'd2);
      prog[11] = enc_rrr(OP_ARITH, 3'd2, 3'd1, 3'b000, 3'd1);
      prog[12] = enc_mem(OP_LDR, 3'd4, 3'd6, 6'd3);
      prog[13] = enc_mem(OP_STR, 3'd4, 3'd6, 6'd5);
      prog[14] = enc_mem(OP_LDR, 3'd0, 3'd6, 6'd5);
      prog[15] = enc_mem(OP_LDR, 3'd7, 3'd6, 6'd7);
      // Branches
      prog[16] = enc_const(3'd0, 9'd0);
      prog[17] = enc_br(3'b101, 9'd2);
      prog[18] = enc_br(3'b010, 9'd2);
      prog[19] = enc_const(3'd1, 9'd5);
      prog[20] = enc_const(3'd1, 9'd6);
      prog[21] = enc_ri(OP_ARITH, 3'd2, 3'd2, 5'b00001);
      prog[22] = enc_br(3'b111, 9'd1);
      prog[23] = enc_const(3'd3, 9'd7);
      prog[24] = enc_const(3'd3, rnd_c);
      prog[25] = enc_br(3'b100, 9'd1);
      prog[26] = enc_ri(OP_ARITH, 3'd3, 3'd3, 5'b00001);
      prog[27] = enc_rrr(OP_ARITH, 3'd4, 3'd3, 3'b000, 3'd2);
      prog[28] = enc_mem(OP_STR, 3'd4, 3'd6, 6'd0);
      prog[29] = enc_mem(OP_LDR, 3'd5, 3'd6, 6'd0);
      prog[30] = '0;
      prog[31] = '0;
   endtask

   // In-order ISA model that fills the expected trace table
   task automatic build_expected();
      word_t      rf [0:7];
      word_t      mem [0:255];
      word_t      insn, pc, val, addr, data, next_pc;
      nzp_t       nzp;
      logic [3:0] op;
      reg_sel_t   d, s, t, prev_wsel;
      logic       we, nzp_we, st, taken, prev_taken, prev_load, rd1, rd2;
      int         idx, n;
      for (int i = 0; i < 8; i++) rf[i] = '0;
      for (int i = 0; i < 256; i++) mem[i] = ram_fill(8'(i));
      nzp = '0;
      idx = 0;
      n = 0;
      prev_taken = 1'b0;
      prev_load = 1'b0;
      prev_wsel = '0;
      while (idx < PROG_LEN && n < MAX_EXP) begin
         insn = prog[idx];
         pc = RESET_PC_DEFAULT + 16'(idx);
         op = insn[15:12];
         d = insn[11:9];
         s = insn[8:6];
         t = insn[2:0];
         {we, nzp_we, st, taken} = 4'b0000;
         val = '0;
         addr = '0;
         data = '0;
         next_pc = pc + 16'd1;
         case (op)
            OP_ARITH: begin
               if (insn[5]) val = rf[s] + {{11{insn[4]}}, insn[4:0]};
               else if (insn[5:3] == 3'b010) val = rf[s] - rf[t];
               else val = rf[s] + rf[t];
               {we, nzp_we} = 2'b11;
            end
            OP_LOGIC: begin
               val = rf[s] & (insn[5] ? {{11{insn[4]}}, insn[4:0]} : rf[t]);
               {we, nzp_we} = 2'b11;
            end
            OP_LDR: begin
               addr = rf[s] + {{10{insn[5]}}, insn[5:0]};
               val = mem[addr[7:0]];
               data = val;
               {we, nzp_we} = 2'b11;
            end
            OP_STR: begin
               addr = rf[s] + {{10{insn[5]}}, insn[5:0]};
               data = rf[d];
               mem[addr[7:0]] = data;
               st = 1'b1;
            end
            OP_CONST: begin
               val = {{7{insn[8]}}, insn[8:0]};
               {we, nzp_we} = 2'b11;
            end
            OP_BR: begin
               taken = |(nzp & d);
               if (taken) next_pc = pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
            end
         endcase
         rd1 = (op == OP_ARITH) || (op == OP_LOGIC) || (op == OP_LDR) || (op == OP_STR);
         rd2 = ((op == OP_ARITH) || (op == OP_LOGIC)) && !insn[5];
         exp_kind[n] = STALL_FLUSH;
         if (n == 0) begin
            exp_bub[n] = -1;
         end else if (prev_taken) begin
            exp_bub[n] = 2;
         end else if (prev_load && ((rd1 && s == prev_wsel) || (rd2 && t == prev_wsel))) begin
            exp_bub[n] = 1;
            exp_kind[n] = STALL_LOAD;
         end else begin
            exp_bub[n] = 0;
         end
         exp_pc[n] = pc;
         exp_insn[n] = insn;
         exp_rf_we[n] = we;
         exp_wsel[n] = d;
         exp_rf_data[n] = val;
         exp_nzp_we[n] = nzp_we;
         exp_nzp[n] = nzp_of(val);
         exp_dmem_we[n] = st;
         exp_addr[n] = addr;
         exp_data[n] = data;
         if (we) rf[d] = val;
         if (nzp_we) nzp = nzp_of(val);
         prev_taken = taken;
         prev_load = (op == OP_LDR);
         prev_wsel = d;
         idx = int'(next_pc - RESET_PC_DEFAULT);
         n++;
      end
      n_exp = n;
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      assert (exp == act) else begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         $display("** FAIL **");
         $fatal(1, "trace check failed");
      end
   endtask

   task automatic check_retire(input int e, input int bubbles);
      string name;
      name = $sformatf("entry %0d pc %h", e, exp_pc[e]);
      if (exp_bub[e] >= 0) check_word({name, " bubbles"}, 16'(exp_bub[e]), 16'(bubbles));
      check_word({name, " pc"}, exp_pc[e], test_pc);
      check_word({name, " insn"}, exp_insn[e], test_insn);
      check_word({name, " regfile_we"}, 16'(exp_rf_we[e]), 16'(test_rf_we));
      if (exp_rf_we[e]) begin
         check_word({name, " wsel"}, 16'(exp_wsel[e]), 16'(test_wsel));
         check_word({name, " regfile_data"}, exp_rf_data[e], test_rf_data);
      end
      check_word({name, " nzp_we"}, 16'(exp_nzp_we[e]), 16'(test_nzp_we));
      if (exp_nzp_we[e]) check_word({name, " nzp"}, 16'(exp_nzp[e]), 16'(test_nzp));
      check_word({name, " dmem_we"}, 16'(exp_dmem_we[e]), 16'(test_dmem_we));
      check_word({name, " dmem_addr"}, exp_addr[e], test_dmem_addr);
      check_word({name, " dmem_data"}, exp_data[e], test_dmem_data);
      // The store wrote the RAM through the memory-port address and data
      if (exp_dmem_we[e]) begin
         check_word({name, " stored word"}, exp_data[e], ram[exp_addr[e][7:0]]);
      end
   endtask

   initial begin
      int e;
      int bubbles;
      build_program();
      build_expected();
      timeout_limit = 3 * n_exp + 20;
      e = 0;
      bubbles = 0;
      @(posedge gwe);
      @(negedge gwe);
      while (reset) begin
         check_word("reset pc", RESET_PC_DEFAULT, cur_pc);
         check_word("reset stall", 16'(STALL_FLUSH), 16'(test_stall));
         assert (!dmem_we && !test_rf_we && !test_nzp_we && !test_dmem_we)
            else stop_run("a memory or register write appeared during reset");
         @(negedge gwe);
      end
      while (e < n_exp) begin
         if (test_stall != STALL_NONE) begin
            check_word($sformatf("stall code before entry %0d", e),
                       16'(exp_kind[e]), 16'(test_stall));
            assert (!test_rf_we && !test_nzp_we && !test_dmem_we)
               else stop_run("a bubble on the trace carried a write enable");
            bubbles++;
         end else begin
            check_retire(e, bubbles);
            e++;
            bubbles = 0;
         end
         @(negedge gwe);
      end
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
rtl/lc4_pkg.sv
rtl/pipe_latch.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_alu.sv
rtl/hazard_unit.sv
rtl/lc4_pipeline.sv
verif/tb_clock.sv
verif/lc4_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the LC4 pipeline testbench with Verilator and runs it.
# The exit status is the verdict: zero on pass, nonzero on any failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module lc4_tb -f src.f -o lc4_sim \
   && ./obj_dir/lc4_sim \
   || { echo "LC4 simulation did not pass"; exit 1; }
